/* source/mem_bridge_params.svh */
`ifndef MEM_BRIDGE_PARAMS_SVH
`define MEM_BRIDGE_PARAMS_SVH

`define AXI_ADDR_W   32
`define AXI_DATA_W   32
`define AXI_ID_W     4
`define LITE_ADDR_W  4
`define CNT_W        32

`define REG_CTRL     4'h0   // bit 0 selects data reads first
`define REG_INST_CNT 4'h4
`define REG_DATA_CNT 4'h8
`define REG_WR_CNT   4'hC

`define ID_DATA      4'd0
`define ID_INST      4'd1

`endif

/* source/axi_pkg.sv */
`include "mem_bridge_params.svh"

package axi_pkg;

    typedef logic [`AXI_ADDR_W-1:0]   axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0]   axi_data_t;
    typedef logic [`AXI_ID_W-1:0]     axi_id_t;
    typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t;
    typedef logic [1:0]               axi_resp_t;
    typedef logic [3:0]               axi_len_t;   // beats minus one, always zero here
    typedef logic [2:0]               axi_size_t;
    typedef logic [`LITE_ADDR_W-1:0]  lite_addr_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;
    localparam axi_size_t SIZE_WORD   = 3'b010;

    // AR and AW share one layout
    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_len_t  len;
        axi_size_t size;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    typedef struct packed {
        lite_addr_t awaddr;
        lite_addr_t araddr;
        axi_data_t  wdata;
        axi_strb_t  wstrb;
    } lite_req_t;

    typedef struct packed {
        axi_data_t rdata;
        axi_resp_t resp;
    } lite_rsp_t;

endpackage

/* source/cpu_port_pkg.sv */
package cpu_port_pkg;

    import axi_pkg::*;

    // request as the CPU presents it, held until addr_ok
    typedef struct packed {
        axi_addr_t addr;
        logic      wr;
        axi_strb_t sel;     // byte lanes of a write
        axi_data_t wdata;
    } sram_req_t;

    typedef struct packed {
        axi_data_t rdata;
        logic      err;     // set on a non-OKAY response
    } sram_rsp_t;

    typedef enum logic {
        RD_IDLE,
        RD_ADDR
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SEND,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        LITE_IDLE,
        LITE_BRESP,
        LITE_RDATA
    } lite_state_e;

endpackage

/* source/axi_read_mux.sv */
`timescale 1ns/1ps
`include "mem_bridge_params.svh"

module axi_read_mux
    import axi_pkg::*;
    import cpu_port_pkg::*;
(
    input  logic      aclk,
    input  logic      arst_n,
    input  logic      inst_req,
    input  axi_addr_t inst_addr,
    output logic      inst_addr_ok,
    output logic      inst_data_ok,
    output sram_rsp_t inst_rsp,
    input  logic      data_rd_req,
    input  axi_addr_t data_addr,
    output logic      data_rd_addr_ok,
    output logic      data_rd_data_ok,
    output sram_rsp_t data_rd_rsp,
    input  logic      data_first,
    output axi_ar_t   ar,
    output logic      arvalid,
    input  logic      arready,
    input  axi_r_t    r,
    input  logic      rvalid,
    output logic      rready,
    output logic      inst_rd_done,
    output logic      data_rd_done
);

    rd_state_e state;
    logic      gnt_inst;    // owner of the AR being offered
    logic      inst_busy;   // fetch read in flight
    logic      data_busy;
    logic      inst_elig;
    logic      data_elig;
    logic      pick_inst;
    logic      grant;
    logic      ar_hs;
    logic      r_inst;
    logic      r_data;

    assign inst_elig = inst_req && !inst_busy;
    assign data_elig = data_rd_req && !data_busy;
    assign pick_inst = inst_elig && !(data_elig && data_first);  // tie goes to ctrl bit
    assign grant     = (state == RD_IDLE) && (inst_elig || data_elig);

    assign arvalid         = (state == RD_ADDR);
    assign ar_hs           = arvalid && arready;
    assign inst_addr_ok    = ar_hs && gnt_inst;
    assign data_rd_addr_ok = ar_hs && !gnt_inst;
    assign inst_rd_done    = inst_addr_ok;
    assign data_rd_done    = data_rd_addr_ok;

    assign rready = 1'b1;
    assign r_inst = rvalid && (r.id == `ID_INST);
    assign r_data = rvalid && (r.id == `ID_DATA);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= RD_IDLE;
            gnt_inst <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (grant) begin
                        state    <= RD_ADDR;
                        gnt_inst <= pick_inst;
                    end
                end
                RD_ADDR: begin
                    if (arready) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (grant) begin
            ar.id   <= pick_inst ? `ID_INST : `ID_DATA;
            ar.addr <= pick_inst ? inst_addr : data_addr;
            ar.len  <= '0;         // single beat only
            ar.size <= SIZE_WORD;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            inst_busy       <= 1'b0;
            data_busy       <= 1'b0;
            inst_data_ok    <= 1'b0;
            data_rd_data_ok <= 1'b0;
        end else begin
            inst_data_ok    <= r_inst;
            data_rd_data_ok <= r_data;
            if (inst_addr_ok) begin
                inst_busy <= 1'b1;
            end else if (r_inst) begin
                inst_busy <= 1'b0;  // free again in the data_ok cycle
            end
            if (data_rd_addr_ok) begin
                data_busy <= 1'b1;
            end else if (r_data) begin
                data_busy <= 1'b0;
            end
        end
    end

    // beats demultiplexed by rid
    always_ff @(posedge aclk) begin
        if (r_inst) begin
            inst_rsp.rdata <= r.data;
            inst_rsp.err   <= (r.resp != RESP_OKAY);
        end
        if (r_data) begin
            data_rd_rsp.rdata <= r.data;
            data_rd_rsp.err   <= (r.resp != RESP_OKAY);
        end
    end

endmodule

/* source/axi_write_channel.sv */
`timescale 1ns/1ps
`include "mem_bridge_params.svh"

module axi_write_channel
    import axi_pkg::*;
    import cpu_port_pkg::*;
(
    input  logic      aclk,
    input  logic      arst_n,
    input  logic      wr_req,
    input  sram_req_t wr,
    output logic      wr_addr_ok,
    output logic      wr_data_ok,
    output sram_rsp_t wr_rsp,
    output axi_aw_t   aw,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  axi_b_t    b,
    input  logic      bvalid,
    output logic      bready,
    output logic      wr_done
);

    wr_state_e state;
    logic      accept;
    logic      aw_left;    // AW still stalled this cycle
    logic      w_left;

    assign accept     = (state == WR_IDLE) && wr_req;
    assign aw_left    = awvalid && !awready;
    assign w_left     = wvalid && !wready;
    assign wr_addr_ok = (state == WR_SEND) && !aw_left && !w_left;
    assign bready     = 1'b1;
    assign wr_done    = (state == WR_RESP) && bvalid;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= WR_IDLE;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            wr_data_ok <= 1'b0;
        end else begin
            wr_data_ok <= wr_done;
            case (state)
                WR_IDLE: begin
                    if (accept) begin
                        state   <= WR_SEND;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                    end
                end
                WR_SEND: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (wr_addr_ok) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (bvalid) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            aw.id   <= `ID_DATA;
            aw.addr <= wr.addr;
            aw.len  <= '0;
            aw.size <= SIZE_WORD;
            w.data  <= wr.wdata;
            w.strb  <= wr.sel;  // byte selects map straight onto strobes
            w.last  <= 1'b1;
        end
        if (wr_done) begin
            wr_rsp.rdata <= '0;
            wr_rsp.err   <= (b.resp != RESP_OKAY);
        end
    end

endmodule

/* source/bridge_cfg_regs.sv */
`timescale 1ns/1ps
`include "mem_bridge_params.svh"

module bridge_cfg_regs
    import axi_pkg::*;
    import cpu_port_pkg::*;
(
    input  logic      aclk,
    input  logic      arst_n,
    input  lite_req_t lite_req,
    input  logic      lite_awvalid,
    input  logic      lite_wvalid,
    input  logic      lite_arvalid,
    input  logic      lite_bready,
    input  logic      lite_rready,
    output logic      lite_awready,
    output logic      lite_wready,
    output logic      lite_arready,
    output logic      lite_bvalid,
    output logic      lite_rvalid,
    output axi_resp_t lite_bresp,
    output lite_rsp_t lite_rsp,
    input  logic      inst_rd_done,
    input  logic      data_rd_done,
    input  logic      wr_done,
    output logic      data_first
);

    lite_state_e       state;
    logic [`CNT_W-1:0] inst_cnt;
    logic [`CNT_W-1:0] data_cnt;
    logic [`CNT_W-1:0] wr_cnt;
    logic              wr_go;
    logic              rd_go;
    axi_resp_t         wr_resp;
    axi_resp_t         rd_resp;
    axi_data_t         rd_val;

    assign wr_go = (state == LITE_IDLE) && lite_awvalid && lite_wvalid;
    assign rd_go = (state == LITE_IDLE) && !wr_go && lite_arvalid;  // writes first

    assign lite_awready = wr_go;
    assign lite_wready  = wr_go;
    assign lite_arready = rd_go;
    assign lite_bvalid  = (state == LITE_BRESP);
    assign lite_rvalid  = (state == LITE_RDATA);

    always_comb begin
        case (lite_req.awaddr)
            `REG_CTRL, `REG_INST_CNT, `REG_DATA_CNT, `REG_WR_CNT: wr_resp = RESP_OKAY;
            default: wr_resp = RESP_SLVERR;
        endcase
    end

    always_comb begin
        rd_resp = RESP_OKAY;
        rd_val  = '0;
        case (lite_req.araddr)
            `REG_CTRL:     rd_val = {{(`AXI_DATA_W-1){1'b0}}, data_first};
            `REG_INST_CNT: rd_val = inst_cnt;
            `REG_DATA_CNT: rd_val = data_cnt;
            `REG_WR_CNT:   rd_val = wr_cnt;
            default:       rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= LITE_IDLE;
            data_first <= 1'b0;
            inst_cnt   <= '0;
            data_cnt   <= '0;
            wr_cnt     <= '0;
        end else begin
            case (state)
                LITE_IDLE: begin
                    if (wr_go) begin
                        state <= LITE_BRESP;
                    end else if (rd_go) begin
                        state <= LITE_RDATA;
                    end
                end
                LITE_BRESP: begin
                    if (lite_bready) begin
                        state <= LITE_IDLE;
                    end
                end
                LITE_RDATA: begin
                    if (lite_rready) begin
                        state <= LITE_IDLE;
                    end
                end
                default: state <= LITE_IDLE;
            endcase
            // only ctrl takes a write, counter offsets drop it
            if (wr_go && lite_req.awaddr == `REG_CTRL && lite_req.wstrb[0]) begin
                data_first <= lite_req.wdata[0];
            end
            if (inst_rd_done) begin
                inst_cnt <= inst_cnt + 1'b1;
            end
            if (data_rd_done) begin
                data_cnt <= data_cnt + 1'b1;
            end
            if (wr_done) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_go) begin
            lite_bresp <= wr_resp;
        end
        if (rd_go) begin
            lite_rsp.rdata <= rd_val;   // sampled at arready
            lite_rsp.resp  <= rd_resp;
        end
    end

endmodule

/* source/mem_bridge_top.sv */
`timescale 1ns/1ps

module mem_bridge_top
    import axi_pkg::*;
    import cpu_port_pkg::*;
(
    input  logic      aclk,
    input  logic      arst_n,
    // fetch port
    input  logic      inst_req,
    input  axi_addr_t inst_addr,
    output logic      inst_addr_ok,
    output logic      inst_data_ok,
    output sram_rsp_t inst_rsp,
    // data port
    input  logic      data_req,
    input  sram_req_t data,
    output logic      data_addr_ok,
    output logic      data_data_ok,
    output sram_rsp_t data_rsp,
    // AXI master
    output axi_ar_t   ar,
    output logic      arvalid,
    input  logic      arready,
    input  axi_r_t    r,
    input  logic      rvalid,
    output logic      rready,
    output axi_aw_t   aw,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  axi_b_t    b,
    input  logic      bvalid,
    output logic      bready,
    // AXI4-Lite slave
    input  lite_req_t lite_req,
    input  logic      lite_awvalid,
    input  logic      lite_wvalid,
    input  logic      lite_arvalid,
    input  logic      lite_bready,
    input  logic      lite_rready,
    output logic      lite_awready,
    output logic      lite_wready,
    output logic      lite_arready,
    output logic      lite_bvalid,
    output logic      lite_rvalid,
    output axi_resp_t lite_bresp,
    output lite_rsp_t lite_rsp
);

    logic      data_rd_req;
    logic      data_wr_req;
    logic      rd_addr_ok;
    logic      rd_data_ok;
    sram_rsp_t rd_rsp;
    logic      wr_addr_ok;
    logic      wr_data_ok;
    sram_rsp_t wr_rsp;
    logic      inst_rd_done;
    logic      data_rd_done;
    logic      wr_done;
    logic      data_first;

    // data port split by direction
    assign data_rd_req = data_req && !data.wr;
    assign data_wr_req = data_req && data.wr;

    assign data_addr_ok = rd_addr_ok | wr_addr_ok;
    assign data_data_ok = rd_data_ok | wr_data_ok;
    assign data_rsp     = wr_data_ok ? wr_rsp : rd_rsp;   // one side answers per cycle

    axi_read_mux u_read_mux (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .inst_req        (inst_req),
        .inst_addr       (inst_addr),
        .inst_addr_ok    (inst_addr_ok),
        .inst_data_ok    (inst_data_ok),
        .inst_rsp        (inst_rsp),
        .data_rd_req     (data_rd_req),
        .data_addr       (data.addr),
        .data_rd_addr_ok (rd_addr_ok),
        .data_rd_data_ok (rd_data_ok),
        .data_rd_rsp     (rd_rsp),
        .data_first      (data_first),
        .ar              (ar),
        .arvalid         (arvalid),
        .arready         (arready),
        .r               (r),
        .rvalid          (rvalid),
        .rready          (rready),
        .inst_rd_done    (inst_rd_done),
        .data_rd_done    (data_rd_done)
    );

    axi_write_channel u_write_channel (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .wr_req     (data_wr_req),
        .wr         (data),
        .wr_addr_ok (wr_addr_ok),
        .wr_data_ok (wr_data_ok),
        .wr_rsp     (wr_rsp),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .b          (b),
        .bvalid     (bvalid),
        .bready     (bready),
        .wr_done    (wr_done)
    );

    bridge_cfg_regs u_cfg_regs (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .lite_req     (lite_req),
        .lite_awvalid (lite_awvalid),
        .lite_wvalid  (lite_wvalid),
        .lite_arvalid (lite_arvalid),
        .lite_bready  (lite_bready),
        .lite_rready  (lite_rready),
        .lite_awready (lite_awready),
        .lite_wready  (lite_wready),
        .lite_arready (lite_arready),
        .lite_bvalid  (lite_bvalid),
        .lite_rvalid  (lite_rvalid),
        .lite_bresp   (lite_bresp),
        .lite_rsp     (lite_rsp),
        .inst_rd_done (inst_rd_done),
        .data_rd_done (data_rd_done),
        .wr_done      (wr_done),
        .data_first   (data_first)
    );

endmodule

/* dv/mem_bridge_props.sv */
`timescale 1ns/1ps

module mem_bridge_props
    import axi_pkg::*;
(
    input logic    aclk,
    input logic    arst_n,
    input logic    ax_valid,
    input logic    ax_ready,
    input axi_ar_t ax,          // AR or AW, same layout
    input logic    w_valid,
    input logic    w_ready,
    input axi_w_t  w
);

    int fail_cnt = 0;

    ax_held: assert property (@(posedge aclk) disable iff (!arst_n)
        ax_valid && !ax_ready |=> ax_valid && $stable(ax))
    else begin
        fail_cnt++;
        $error("address valid dropped or payload changed before ready");
    end

    ax_single_beat: assert property (@(posedge aclk) disable iff (!arst_n)
        ax_valid |-> ax.len == '0)
    else begin
        fail_cnt++;
        $error("burst length is not zero on a single-beat transfer");
    end

    w_held: assert property (@(posedge aclk) disable iff (!arst_n)
        w_valid && !w_ready |=> w_valid && $stable(w))
    else begin
        fail_cnt++;
        $error("write data valid dropped or payload changed before ready");
    end

endmodule

bind axi_read_mux mem_bridge_props u_rd_props (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .ax_valid (arvalid),
    .ax_ready (arready),
    .ax       (ar),
    .w_valid  (1'b0),       // no write data on the read side
    .w_ready  (1'b1),
    .w        ('0)
);

bind axi_write_channel mem_bridge_props u_wr_props (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .ax_valid (awvalid),
    .ax_ready (awready),
    .ax       (aw),
    .w_valid  (wvalid),
    .w_ready  (wready),
    .w        (w)
);

/* dv/mem_bridge_tb.sv */
`timescale 1ns/1ps
`include "mem_bridge_params.svh"

module mem_bridge_tb
    import axi_pkg::*;
    import cpu_port_pkg::*;
();

    localparam int         N_ROWS   = 22;
    localparam int         LIMIT    = N_ROWS * 200;   // watchdog budget in cycles
    localparam axi_addr_t  ERR_BASE = 32'hF000_0000;
    localparam axi_data_t  PATTERN  = 32'h5A5A_0000;
    localparam lite_addr_t UNMAPPED = 4'h6;           // a hole in the register map

    typedef enum logic [1:0] {
        P_INST,
        P_DATA,
        P_CTRL      // Lite write of ctrl with the priority in wdata bit 0
    } port_e;

    typedef struct {
        port_e     port;
        logic      wr;
        axi_addr_t addr;
        axi_data_t wdata;
        axi_strb_t sel;
        axi_data_t exp_rdata;
        logic      exp_err;
        logic      pair;        // issued in the same cycle as the next row
    } stim_t;

    logic      aclk = 1'b0;
    logic      arst_n;
    logic      inst_req;
    axi_addr_t inst_addr;
    logic      inst_addr_ok;
    logic      inst_data_ok;
    sram_rsp_t inst_rsp;
    logic      data_req;
    sram_req_t data;
    logic      data_addr_ok;
    logic      data_data_ok;
    sram_rsp_t data_rsp;
    axi_ar_t   ar;
    logic      arvalid;
    logic      arready;
    axi_r_t    r;
    logic      rvalid;
    logic      rready;
    axi_aw_t   aw;
    logic      awvalid;
    logic      awready;
    axi_w_t    w;
    logic      wvalid;
    logic      wready;
    axi_b_t    b;
    logic      bvalid;
    logic      bready;
    lite_req_t lite_req;
    logic      lite_awvalid;
    logic      lite_wvalid;
    logic      lite_arvalid;
    logic      lite_bready;
    logic      lite_rready;
    logic      lite_awready;
    logic      lite_wready;
    logic      lite_arready;
    logic      lite_bvalid;
    logic      lite_rvalid;
    axi_resp_t lite_bresp;
    lite_rsp_t lite_rsp;

    stim_t     stim [N_ROWS];
    axi_data_t mem [axi_addr_t];    // words written so far
    axi_ar_t   rd_q [$];            // accepted reads waiting for R
    axi_b_t    b_q [$];
    axi_id_t   ar_ids [$];          // id of every AR handshake in order
    axi_aw_t   aw_hold;
    axi_w_t    w_hold;
    logic      aw_got;
    logic      w_got;
    logic      ctrl_shadow;
    integer    seed        = 87740;
    int        err_cnt     = 0;
    int        chk_cnt     = 0;
    int        n_inst      = 0;
    int        n_dread     = 0;
    int        n_write     = 0;
    int        inst_ok_cnt = 0;
    int        data_ok_cnt = 0;

    mem_bridge_top UUT (.*);

    always #10 aclk = ~aclk;

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic stim_t row(input port_e port, input logic wr, input axi_addr_t addr,
                                  input axi_data_t wdata, input axi_strb_t sel,
                                  input axi_data_t exp_rdata, input logic exp_err,
                                  input logic pair);
        stim_t s;
        s = '{port, wr, addr, wdata, sel, exp_rdata, exp_err, pair};
        return s;
    endfunction

    function automatic axi_data_t stored_word(input axi_addr_t addr);
        return mem.exists(addr) ? mem[addr] : (addr ^ PATTERN);
    endfunction

    function automatic axi_r_t read_beat(input axi_ar_t a);
        axi_r_t beat;
        beat.id   = a.id;
        beat.last = 1'b1;
        if (a.addr >= ERR_BASE) begin
            beat.data = '0;
            beat.resp = RESP_SLVERR;
        end else begin
            beat.data = stored_word(a.addr);
            beat.resp = RESP_OKAY;
        end
        return beat;
    endfunction

    function automatic axi_resp_t write_word(input axi_addr_t addr, input axi_w_t d);
        axi_data_t word;
        if (addr >= ERR_BASE) begin
            return RESP_SLVERR;
        end
        word = stored_word(addr);
        for (int i = 0; i < 4; i++) begin
            if (d.strb[i]) begin
                word[8*i +: 8] = d.data[8*i +: 8];
            end
        end
        mem[addr] = word;
        return RESP_OKAY;
    endfunction

    // one request on the fetch or data port from req to data_ok
    task automatic sram_access(input int k);
        stim_t     s;
        sram_rsp_t rsp;
        s = stim[k];
        if (s.port == P_INST) begin
            inst_req  <= 1'b1;
            inst_addr <= s.addr;
            do @(posedge aclk); while (!inst_addr_ok);
            inst_req <= 1'b0;
            do @(posedge aclk); while (!inst_data_ok);
            rsp = inst_rsp;
            n_inst++;
        end else begin
            data_req <= 1'b1;
            data     <= '{addr: s.addr, wr: s.wr, sel: s.sel, wdata: s.wdata};
            do @(posedge aclk); while (!data_addr_ok);
            data_req <= 1'b0;
            do @(posedge aclk); while (!data_data_ok);
            rsp = data_rsp;
            if (s.wr) begin
                n_write++;
            end else begin
                n_dread++;
            end
        end
        if (!s.wr) begin
            compare(rsp.rdata, s.exp_rdata, $sformatf("row %0d rdata", k));
        end
        compare(rsp.err, s.exp_err, $sformatf("row %0d err", k));
    endtask

    task automatic lite_write(input lite_addr_t addr, input axi_data_t value,
                              input axi_resp_t exp);
        lite_req.awaddr <= addr;
        lite_req.wdata  <= value;
        lite_req.wstrb  <= 4'hF;
        lite_awvalid    <= 1'b1;
        lite_wvalid     <= 1'b1;
        do @(posedge aclk); while (!lite_awready);
        compare(lite_wready, 1'b1, $sformatf("Lite wready with awready at offset %h", addr));
        lite_awvalid <= 1'b0;
        lite_wvalid  <= 1'b0;
        do @(posedge aclk); while (!lite_bvalid);
        compare(lite_bresp, exp, $sformatf("Lite write resp at offset %h", addr));
    endtask

    task automatic lite_read(input lite_addr_t addr, input axi_data_t value,
                             input axi_resp_t exp);
        lite_req.araddr <= addr;
        lite_arvalid    <= 1'b1;
        do @(posedge aclk); while (!lite_arready);
        lite_arvalid <= 1'b0;
        do @(posedge aclk); while (!lite_rvalid);
        compare(lite_rsp.resp, exp, $sformatf("Lite read resp at offset %h", addr));
        if (exp == RESP_OKAY) begin
            compare(lite_rsp.rdata, value, $sformatf("Lite read data at offset %h", addr));
        end
    endtask

    // AXI slave memory with random ready and valid delays
    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        b       = '0;
        aw_got  = 1'b0;
        w_got   = 1'b0;
        forever begin
            @(posedge aclk);
            if (arvalid && arready) begin
                rd_q.push_back(ar);
                ar_ids.push_back(ar.id);
            end
            if (awvalid && awready) begin
                aw_hold = aw;
                aw_got  = 1'b1;
            end
            if (wvalid && wready) begin
                w_hold = w;
                w_got  = 1'b1;
            end
            if (aw_got && w_got) begin
                b_q.push_back('{id: aw_hold.id, resp: write_word(aw_hold.addr, w_hold)});
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
            arready <= arst_n && (($random(seed) & 3) != 0);
            awready <= arst_n && (($random(seed) & 3) != 0);
            wready  <= arst_n && (($random(seed) & 3) != 0);
            if (rvalid) begin
                if (rready) begin
                    rvalid <= 1'b0;
                end
            end else if (rd_q.size() > 0 && ($random(seed) & 1)) begin
                r      <= read_beat(rd_q.pop_front());
                rvalid <= 1'b1;
            end
            if (bvalid) begin
                if (bready) begin
                    bvalid <= 1'b0;
                end
            end else if (b_q.size() > 0 && ($random(seed) & 1)) begin
                b      <= b_q.pop_front();
                bvalid <= 1'b1;
            end
        end
    end

    always @(posedge aclk) begin
        if (inst_data_ok === 1'b1) begin
            inst_ok_cnt++;
        end
        if (data_data_ok === 1'b1) begin
            data_ok_cnt++;
        end
    end

    initial begin
        repeat (LIMIT) @(posedge aclk);
        $display("ERROR: watchdog expired after %0d cycles, a handshake never completed", LIMIT);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int i;
        int mark;
        arst_n       = 1'b0;
        inst_req     = 1'b0;
        inst_addr    = '0;
        data_req     = 1'b0;
        data         = '0;
        lite_req     = '0;
        lite_awvalid = 1'b0;
        lite_wvalid  = 1'b0;
        lite_arvalid = 1'b0;
        lite_bready  = 1'b0;
        lite_rready  = 1'b0;
        ctrl_shadow  = 1'b0;

        stim[0]  = row(P_INST, 1'b0, 32'h0000_1000, 32'h0, 4'h0, 32'h5A5A_1000, 1'b0, 1'b0);
        stim[1]  = row(P_INST, 1'b0, 32'h0000_1004, 32'h0, 4'h0, 32'h5A5A_1004, 1'b0, 1'b0);
        stim[2]  = row(P_DATA, 1'b1, 32'h0000_2000, 32'hDEAD_BEEF, 4'hF, 32'h0, 1'b0, 1'b0);
        stim[3]  = row(P_DATA, 1'b0, 32'h0000_2000, 32'h0, 4'h0, 32'hDEAD_BEEF, 1'b0, 1'b0);
        stim[4]  = row(P_DATA, 1'b1, 32'h0000_2000, 32'h1122_3344, 4'h5, 32'h0, 1'b0, 1'b0);
        stim[5]  = row(P_DATA, 1'b0, 32'h0000_2000, 32'h0, 4'h0, 32'hDE22_BE44, 1'b0, 1'b0);
        stim[6]  = row(P_DATA, 1'b1, 32'h0000_3000, 32'h0000_00A5, 4'h1, 32'h0, 1'b0, 1'b0);
        stim[7]  = row(P_DATA, 1'b0, 32'h0000_3000, 32'h0, 4'h0, 32'h5A5A_30A5, 1'b0, 1'b0);
        stim[8]  = row(P_INST, 1'b0, 32'h0000_3000, 32'h0, 4'h0, 32'h5A5A_30A5, 1'b0, 1'b0);
        stim[9]  = row(P_INST, 1'b0, 32'h0000_4000, 32'h0, 4'h0, 32'h5A5A_4000, 1'b0, 1'b1);
        stim[10] = row(P_DATA, 1'b0, 32'h0000_4100, 32'h0, 4'h0, 32'h5A5A_4100, 1'b0, 1'b0);
        stim[11] = row(P_CTRL, 1'b1, 32'h0, 32'h0000_0001, 4'hF, 32'h0, 1'b0, 1'b0);
        stim[12] = row(P_INST, 1'b0, 32'h0000_5000, 32'h0, 4'h0, 32'h5A5A_5000, 1'b0, 1'b1);
        stim[13] = row(P_DATA, 1'b0, 32'h0000_2000, 32'h0, 4'h0, 32'hDE22_BE44, 1'b0, 1'b0);
        stim[14] = row(P_CTRL, 1'b1, 32'h0, 32'h0000_0000, 4'hF, 32'h0, 1'b0, 1'b0);
        stim[15] = row(P_DATA, 1'b0, 32'h0000_6000, 32'h0, 4'h0, 32'h5A5A_6000, 1'b0, 1'b1);
        stim[16] = row(P_INST, 1'b0, 32'h0000_6004, 32'h0, 4'h0, 32'h5A5A_6004, 1'b0, 1'b0);
        stim[17] = row(P_INST, 1'b0, 32'hF000_0000, 32'h0, 4'h0, 32'h0, 1'b1, 1'b0);
        stim[18] = row(P_DATA, 1'b0, 32'hF000_0010, 32'h0, 4'h0, 32'h0, 1'b1, 1'b0);
        stim[19] = row(P_DATA, 1'b1, 32'hFFFF_FFF0, 32'h1234_5678, 4'hF, 32'h0, 1'b1, 1'b0);
        stim[20] = row(P_DATA, 1'b0, 32'hFFFF_FFF0, 32'h0, 4'h0, 32'h0, 1'b1, 1'b0);
        stim[21] = row(P_DATA, 1'b0, 32'hEFFF_FFFC, 32'h0, 4'h0, 32'hB5A5_FFFC, 1'b0, 1'b0);

        repeat (8) @(posedge aclk);
        arst_n      <= 1'b1;
        lite_bready <= 1'b1;
        lite_rready <= 1'b1;
        repeat (2) @(posedge aclk);

        i = 0;
        while (i < N_ROWS) begin
            @(posedge aclk);
            if (stim[i].port == P_CTRL) begin
                lite_write(`REG_CTRL, stim[i].wdata, RESP_OKAY);
                lite_read(`REG_CTRL, {31'b0, stim[i].wdata[0]}, RESP_OKAY);
                ctrl_shadow = stim[i].wdata[0];
                i = i + 1;
            end else if (stim[i].pair) begin
                mark = ar_ids.size();
                fork
                    sram_access(i);
                    sram_access(i + 1);
                join
                // a same-cycle tie goes to the source named by ctrl bit 0
                compare(ar_ids[mark], ctrl_shadow ? `ID_DATA : `ID_INST,
                        $sformatf("first AR id of rows %0d and %0d", i, i + 1));
                i = i + 2;
            end else begin
                sram_access(i);
                i = i + 1;
            end
        end

        @(posedge aclk);
        lite_write(`REG_WR_CNT, 32'hFFFF_FFFF, RESP_OKAY);   // read-only so the value is dropped
        lite_read(`REG_INST_CNT, n_inst, RESP_OKAY);
        lite_read(`REG_DATA_CNT, n_dread, RESP_OKAY);
        lite_read(`REG_WR_CNT, n_write, RESP_OKAY);
        lite_write(UNMAPPED, 32'h0000_0001, RESP_SLVERR);
        lite_read(UNMAPPED, 32'h0, RESP_SLVERR);
        compare(inst_ok_cnt, n_inst, "fetch data_ok pulses");
        compare(data_ok_cnt, n_dread + n_write, "data port data_ok pulses");
        compare(UUT.u_read_mux.u_rd_props.fail_cnt + UUT.u_write_channel.u_wr_props.fail_cnt,
                0, "bound assertion failures");

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+source
source/axi_pkg.sv
source/cpu_port_pkg.sv
source/axi_read_mux.sv
source/axi_write_channel.sv
source/bridge_cfg_regs.sv
source/mem_bridge_top.sv
dv/mem_bridge_props.sv
dv/mem_bridge_tb.sv

/* Bender.yml */
package:
  name: mem_bridge

sources:
  - include_dirs:
      - source
    files:
      - source/axi_pkg.sv
      - source/cpu_port_pkg.sv
      - source/axi_read_mux.sv
      - source/axi_write_channel.sv
      - source/bridge_cfg_regs.sv
      - source/mem_bridge_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/mem_bridge_props.sv
      - dv/mem_bridge_tb.sv
